// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the overlay testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module text_overlay_tb -f sim.f -o text_overlay_sim
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

output=$(./obj_dir/text_overlay_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "ALL TESTS PASSED"; then
	exit 0
fi
echo "simulation reported failures"
exit 1

// ==== sim.f ====
src/text_overlay_pkg.sv
src/cell_if.sv
src/glyph_rom.sv
src/text_line_slice.sv
src/cell_tracker.sv
src/pixel_compositor.sv
src/text_overlay_top.sv
tb/tb_clock_gen.sv
tb/text_overlay_tb.sv

// ==== src/cell_if.sv ====
`timescale 1ns/1ps

// cell position of the current pixel, shared by tracker, slices and compositor
interface cell_if import text_overlay_pkg::*; #(
	parameter int COLS = 20,
	parameter int LINES = 4
);
	localparam int COL_W = cnt_width(COLS + 1);	// room for one step past the last column
	localparam int LINE_W = cnt_width(LINES + 1);

	logic in_box;	// both offsets nonzero
	logic in_text;	// past the padding on both axes
	logic [COL_W-1:0] col;	// character column
	logic [LINE_W-1:0] line;	// text line
	glyph_col_t gx;	// column inside the cell
	glyph_row_t gy;	// row inside the glyph

	modport tracker (output in_box, output in_text, output col, output line,
		output gx, output gy);
	modport slice (input col, input line, input gx, input gy);
	modport compositor (input in_box, input in_text, input gx);
endinterface

// ==== src/cell_tracker.sv ====
`timescale 1ns/1ps

// follows the raster through the box with counters only, no dividers
module cell_tracker import text_overlay_pkg::*; #(
	parameter int SCALE = 3,
	parameter coord_t X_LOC = 11'd70,
	parameter coord_t Y_LOC = 11'd50,
	parameter int COLS = 20,
	parameter int LINES = 4
) (
	input logic clk,
	input logic rst,
	input coord_t hc,
	input coord_t vc,
	cell_if.tracker cells
);
	localparam coord_t BOX_W = coord_t'(box_width(COLS, SCALE));
	localparam coord_t BOX_H = coord_t'(box_height(LINES, SCALE));
	localparam coord_t X_END = X_LOC + BOX_W;	// closed range, edge included
	localparam coord_t Y_END = Y_LOC + BOX_H;
	localparam coord_t PAD = coord_t'(SCALE);	// one scaled pixel of padding
	localparam int SC_W = cnt_width(SCALE);
	localparam int COL_W = cnt_width(COLS + 1);
	localparam int LINE_W = cnt_width(LINES + 1);
	localparam logic [SC_W-1:0] SC_LAST = SC_W'(SCALE - 1);

	coord_t x_off;	// hc relative to the box, 0 outside
	coord_t y_off;
	logic in_box;
	logic in_text_x;	// horizontal text run, needs the box too
	logic in_text_y;
	logic x_run;	// previous pixel was in the text run

	logic [SC_W-1:0] sx_q, sx_d;	// horizontal scale counter
	logic [SC_W-1:0] sy_q, sy_d;	// vertical scale counter
	glyph_col_t gx_q, gx_d;
	glyph_row_t gy_q, gy_d;
	logic [COL_W-1:0] col_q, col_d;
	logic [LINE_W-1:0] line_q, line_d;

	assign x_off = ((hc >= X_LOC) && (hc <= X_END)) ? hc - X_LOC : '0;
	assign y_off = ((vc >= Y_LOC) && (vc <= Y_END)) ? vc - Y_LOC : '0;
	assign in_box = (x_off > 0) && (y_off > 0);
	assign in_text_x = in_box && (x_off > PAD);
	assign in_text_y = y_off > PAD;

	////////////////////////////////////////
	// horizontal, steps every pixel
	////////////////////////////////////////
	always_comb
	begin
		sx_d = '0;	// first text pixel or outside the run
		gx_d = '0;
		col_d = '0;
		if (in_text_x && x_run)
		begin
			if (sx_q == SC_LAST)
			begin
				sx_d = '0;
				if (gx_q == glyph_col_t'(CELL_W - 1))
				begin
					gx_d = '0;	// gap done, next character
					col_d = col_q + 1'b1;
				end
				else
				begin
					gx_d = gx_q + 1'b1;
					col_d = col_q;
				end
			end
			else
			begin
				sx_d = sx_q + 1'b1;
				gx_d = gx_q;
				col_d = col_q;
			end
		end
	end

	////////////////////////////////////////
	// vertical, steps at the right edge
	////////////////////////////////////////
	always_comb
	begin
		sy_d = '0;	// above the text or outside the box
		gy_d = '0;
		line_d = '0;
		if (in_text_y)
		begin
			sy_d = sy_q;	// hold along the scan line
			gy_d = gy_q;
			line_d = line_q;
			if (x_off == BOX_W)	// edge pixel is always a gap pixel
			begin
				if (sy_q == SC_LAST)
				begin
					sy_d = '0;
					if (gy_q == glyph_row_t'(GLYPH_H - 1))
					begin
						gy_d = '0;
						line_d = line_q + 1'b1;
					end
					else
						gy_d = gy_q + 1'b1;
				end
				else
					sy_d = sy_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			x_run <= 1'b0;
			sx_q <= '0;
			sy_q <= '0;
			gx_q <= '0;
			gy_q <= '0;
			col_q <= '0;
			line_q <= '0;
		end
		else
		begin
			x_run <= in_text_x;
			sx_q <= sx_d;
			sy_q <= sy_d;
			gx_q <= gx_d;
			gy_q <= gy_d;
			col_q <= col_d;
			line_q <= line_d;
		end
	end

	// next values describe the pixel on hc, vc right now
	assign cells.in_box = in_box;
	assign cells.in_text = in_text_x && in_text_y;
	assign cells.col = col_d;
	assign cells.line = line_d;
	assign cells.gx = gx_d;
	assign cells.gy = gy_d;
endmodule

// ==== src/glyph_rom.sv ====
`timescale 1ns/1ps

// 5x8 font for space, 0-9 and A-F, anything else is blank
module glyph_rom import text_overlay_pkg::*; (
	input char_t code,
	input glyph_col_t gx,
	input glyph_row_t gy,
	output logic pixel
);
	glyph_bits_t glyph;	// eight rows of five, row 0 first
	logic [GLYPH_W-1:0] row_bits;	// msb is the leftmost column

	////////////////////////////////////////
	// font table
	////////////////////////////////////////
	always_comb
	begin
		case (code)
			" ": glyph = '0;
			"0": glyph = 40'b01110_10001_10011_10101_11001_10001_01110_00000;
			"1": glyph = 40'b00100_01100_00100_00100_00100_00100_01110_00000;
			"2": glyph = 40'b01110_10001_00001_00010_00100_01000_11111_00000;
			"3": glyph = 40'b11111_00010_00100_00010_00001_10001_01110_00000;
			"4": glyph = 40'b00010_00110_01010_10010_11111_00010_00010_00000;
			"5": glyph = 40'b11111_10000_11110_00001_00001_10001_01110_00000;
			"6": glyph = 40'b00110_01000_10000_11110_10001_10001_01110_00000;
			"7": glyph = 40'b11111_00001_00010_00100_01000_01000_01000_00000;
			"8": glyph = 40'b01110_10001_10001_01110_10001_10001_01110_00000;
			"9": glyph = 40'b01110_10001_10001_01111_00001_00010_01100_00000;
			"A": glyph = 40'b01110_10001_10001_11111_10001_10001_10001_00000;
			"B": glyph = 40'b11110_10001_10001_11110_10001_10001_11110_00000;
			"C": glyph = 40'b01110_10001_10000_10000_10000_10001_01110_00000;
			"D": glyph = 40'b11100_10010_10001_10001_10001_10010_11100_00000;
			"E": glyph = 40'b11111_10000_10000_11110_10000_10000_11111_00000;
			"F": glyph = 40'b11111_10000_10000_11110_10000_10000_10000_00000;
			default: glyph = '0;	// unsupported code draws nothing
		endcase
	end

	////////////////////////////////////////
	// bit select
	////////////////////////////////////////
	assign row_bits = glyph[GLYPH_W*(GLYPH_H-1-int'(gy)) +: GLYPH_W];	// row 0 at the top

	// gap column and beyond read as blank
	assign pixel = (gx < GLYPH_W) ? row_bits[GLYPH_W-1-int'(gx)] : 1'b0;
endmodule

// ==== src/pixel_compositor.sv ====
`timescale 1ns/1ps

// merges the line bits and registers the two overlay outputs
module pixel_compositor import text_overlay_pkg::*; #(
	parameter int LINES = 4
) (
	input logic clk,
	input logic rst,
	cell_if.compositor cells,
	input logic [LINES-1:0] line_pixels,	// one bit per slice
	output logic in_square,
	output logic in_character
);
	logic any_line;	// at most one slice is active
	logic glyph_col;	// not the separator column
	logic char_d;

	assign any_line = |line_pixels;
	assign glyph_col = cells.gx < GLYPH_W;

	// padding strip and gap column never draw
	assign char_d = any_line && cells.in_text && glyph_col;

	////////////////////////////////////////
	// output registers, one cycle latency
	////////////////////////////////////////
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			in_square <= 1'b0;
			in_character <= 1'b0;
		end
		else
		begin
			in_square <= cells.in_box;	// background, padding included
			in_character <= char_d;	// foreground
		end
	end
endmodule

// ==== src/text_line_slice.sv ====
`timescale 1ns/1ps

// one text line of the box, gives its glyph bit for the current pixel
module text_line_slice import text_overlay_pkg::*; #(
	parameter int COLS = 20,
	parameter int LINE_IDX = 0
) (
	input logic [8*COLS-1:0] line_text,	// column 0 in the top byte
	cell_if.slice cells,
	output logic pixel
);
	char_t code;	// character under the beam
	logic rom_pixel;
	logic line_hit;	// beam is on this line

	// byte pick, column 0 is the highest byte
	always_comb
	begin
		if (cells.col < COLS)
			code = line_text[8*(COLS-1-int'(cells.col)) +: 8];
		else
			code = " ";	// past the last column, blank
	end

	glyph_rom u_rom (
		.code (code),
		.gx (cells.gx),
		.gy (cells.gy),
		.pixel (rom_pixel)
	);

	assign line_hit = int'(cells.line) == LINE_IDX;
	assign pixel = line_hit ? rom_pixel : 1'b0;	// other lines own this pixel
endmodule

// ==== src/text_overlay_pkg.sv ====
// shared definitions for the character overlay

package text_overlay_pkg;

	////////////////////////////////////////
	// raster and text types
	////////////////////////////////////////
	typedef logic [10:0] coord_t;	// hc, vc and box offsets
	typedef logic [7:0] char_t;	// one character code

	////////////////////////////////////////
	// glyph geometry
	////////////////////////////////////////
	localparam int GLYPH_W = 5;	// drawn glyph columns
	localparam int GLYPH_H = 8;	// glyph rows, last one blank in the font
	localparam int CELL_W = GLYPH_W + 1;	// plus the blank separator column

	typedef logic [2:0] glyph_col_t;	// 0..5, 5 is the gap
	typedef logic [2:0] glyph_row_t;	// 0..7
	typedef logic [GLYPH_W*GLYPH_H-1:0] glyph_bits_t;	// row 0 in the top bits

	// box width in raster pixels, one scaled pixel of left padding
	function automatic int box_width(int cols, int scale);
		return CELL_W * cols * scale + scale;
	endfunction

	// box height, one scaled pixel of top padding
	function automatic int box_height(int lines, int scale);
		return GLYPH_H * lines * scale + scale;
	endfunction

	// bits needed to count 0..n-1, never less than one
	function automatic int cnt_width(int n);
		return (n > 1) ? $clog2(n) : 1;
	endfunction

endpackage

// ==== src/text_overlay_top.sv ====
`timescale 1ns/1ps

// character box overlay on a vga raster
module text_overlay_top import text_overlay_pkg::*; #(
	parameter int SCALE = 3,	// size of one glyph pixel
	parameter coord_t X_LOC = 11'd70,	// box origin
	parameter coord_t Y_LOC = 11'd50,
	parameter int COLS = 20,	// characters per line
	parameter int LINES = 4
) (
	input logic clk,
	input logic rst,
	input coord_t hc,
	input coord_t vc,
	input logic [8*COLS*LINES-1:0] text,	// line 0 in the top bits
	output logic in_square,
	output logic in_character
);
	localparam int LINE_BITS = 8 * COLS;

	cell_if #(.COLS(COLS), .LINES(LINES)) cells ();
	logic [LINES-1:0] line_pixels;	// glyph bit from each line

	cell_tracker #(
		.SCALE (SCALE),
		.X_LOC (X_LOC),
		.Y_LOC (Y_LOC),
		.COLS (COLS),
		.LINES (LINES)
	) u_tracker (
		.clk (clk),
		.rst (rst),
		.hc (hc),
		.vc (vc),
		.cells (cells)
	);

	// one slice per text line
	for (genvar i = 0; i < LINES; i++)
	begin : g_line
		text_line_slice #(
			.COLS (COLS),
			.LINE_IDX (i)
		) u_slice (
			.line_text (text[LINE_BITS*(LINES-1-i) +: LINE_BITS]),
			.cells (cells),
			.pixel (line_pixels[i])
		);
	end

	pixel_compositor #(.LINES(LINES)) u_comp (
		.clk (clk),
		.rst (rst),
		.cells (cells),
		.line_pixels (line_pixels),
		.in_square (in_square),
		.in_character (in_character)
	);
endmodule

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

// free running clock and a short power-on reset
module tb_clock_gen #(
	parameter int PERIOD = 4,	// ns
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic rst
);
	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a rising edge, the flops still see reset at that edge
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	end
endmodule

// ==== tb/text_overlay_tb.sv ====
`timescale 1ns/1ps

// raster sweep over a small box, checked against a pixel model
module text_overlay_tb import text_overlay_pkg::*; ();
	localparam int SCALE = 2;
	localparam coord_t X_LOC = 11'd20;
	localparam coord_t Y_LOC = 11'd10;
	localparam int COLS = 4;
	localparam int LINES = 2;
	localparam int BOX_W = 50;	// 6*4*2 + 2
	localparam int BOX_H = 34;	// 8*2*2 + 2
	localparam int H_TOTAL = 100;	// raster size
	localparam int V_TOTAL = 60;
	localparam int FRAME_LIMIT = H_TOTAL * V_TOTAL + 50;

	// font copy, row 0 first, leftmost column in the top bit of a row
	localparam logic [39:0] FONT_0 = 40'b01110_10001_10011_10101_11001_10001_01110_00000;
	localparam logic [39:0] FONT_1 = 40'b00100_01100_00100_00100_00100_00100_01110_00000;
	localparam logic [39:0] FONT_A = 40'b01110_10001_10001_11111_10001_10001_10001_00000;
	localparam logic [39:0] FONT_F = 40'b11111_10000_10000_11110_10000_10000_10000_00000;

	logic clk, rst;
	coord_t hc, vc;
	logic [8*COLS*LINES-1:0] text;	// line 0, column 0 in the top byte
	logic in_square, in_character;

	int checks, sq_errors, ch_errors, other_errors, timeouts;
	int seed;
	logic exp_sq_q, exp_ch_q;	// model, one cycle behind the beam
	logic nodraw_q, blank_q, rst_q;
	bit model_ready;	// model holds a pixel to compare
	char_t charset [5] = '{"0", "1", "A", "F", " "};

	tb_clock_gen #(.PERIOD(4), .RESET_CYCLES(3)) u_clk (.clk(clk), .rst(rst));

	text_overlay_top #(
		.SCALE (SCALE), .X_LOC (X_LOC), .Y_LOC (Y_LOC), .COLS (COLS), .LINES (LINES)
	) UUT (
		.clk (clk), .rst (rst), .hc (hc), .vc (vc), .text (text),
		.in_square (in_square), .in_character (in_character)
	);

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	function automatic logic font_bit(char_t code, int gx, int gy);
		logic [39:0] entry;
		case (code)
			"0": entry = FONT_0;
			"1": entry = FONT_1;
			"A": entry = FONT_A;
			"F": entry = FONT_F;
			default: entry = '0;	// space and anything unsupported
		endcase
		if (gx >= GLYPH_W)
			return 1'b0;	// separator column
		return entry[39 - (gy * GLYPH_W + gx)];
	endfunction

	function automatic char_t char_at(int line_no, int col);
		return text[8*COLS*LINES - 1 - 8*(line_no*COLS + col) -: 8];
	endfunction

	function automatic logic draws(char_t code);
		return (code == "0") || (code == "1") || (code == "A") || (code == "F");
	endfunction

	// outputs now belong to the pixel seen at the last negedge
	always @(negedge clk)
	begin : check_and_model
		int h, v, xo, yo, tx, ty, gx, gy, col, line_no;
		logic sq, txt;
		char_t code;
		if (model_ready)	// first pass only primes the model
		begin
			checks++;
			assert (in_square === exp_sq_q) else
			begin
				$display("mismatch at %0t: in_square expected %b, got %b", $time, exp_sq_q,
					in_square);
				sq_errors++;
			end
			assert (in_character === exp_ch_q) else
			begin
				$display("mismatch at %0t: in_character expected %b, got %b", $time, exp_ch_q,
					in_character);
				ch_errors++;
			end
			if (rst || rst_q)	// in reset and the cycle right after
				assert (in_square === 1'b0 && in_character === 1'b0) else
				begin
					$display("outputs not cleared by reset at %0t", $time);
					other_errors++;
				end
			if (nodraw_q)
				assert (in_character === 1'b0) else
				begin
					$display("padding or gap column pixel drawn at %0t", $time);
					other_errors++;
				end
			if (blank_q)
				assert (in_square === 1'b1 && in_character === 1'b0) else
				begin
					$display("blank character cell not plain background at %0t", $time);
					other_errors++;
				end
		end

		// next expectation from the position rule
		h = int'(hc);
		v = int'(vc);
		xo = (h >= X_LOC && h <= X_LOC + BOX_W) ? h - X_LOC : 0;	// closed range
		yo = (v >= Y_LOC && v <= Y_LOC + BOX_H) ? v - Y_LOC : 0;
		sq = (xo > 0) && (yo > 0);
		txt = sq && (xo > SCALE) && (yo > SCALE);
		exp_ch_q <= 1'b0;
		blank_q <= 1'b0;
		nodraw_q <= sq && !txt;	// padding strip
		if (txt)
		begin
			tx = xo - SCALE - 1;
			ty = yo - SCALE - 1;
			col = tx / (CELL_W * SCALE);
			gx = (tx / SCALE) % CELL_W;
			line_no = ty / (GLYPH_H * SCALE);
			gy = (ty / SCALE) % GLYPH_H;
			code = char_at(line_no, col);
			exp_ch_q <= !rst && font_bit(code, gx, gy);
			nodraw_q <= (gx == CELL_W - 1);
			blank_q <= !rst && !draws(code);
		end
		exp_sq_q <= !rst && sq;
		rst_q <= rst;
		model_ready <= 1'b1;
	end

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic run_frame(input int frame);
		int h, v, cycles;
		logic done;
		h = 0;
		v = 0;
		cycles = 0;
		done = 1'b0;
		while (!done && cycles < FRAME_LIMIT)
		begin
			@(posedge clk);
			hc <= coord_t'(h);
			vc <= coord_t'(v);
			cycles++;
			if (h == H_TOTAL - 1)
			begin
				h = 0;
				if (v == V_TOTAL - 1)
					done = 1'b1;
				else
					v++;
			end
			else
				h++;
		end
		if (!done)
		begin
			$display("timeout: frame %0d did not finish its raster", frame);
			timeouts++;
		end
	endtask

	initial
	begin : main
		int guard, pick;
		logic [8*COLS*LINES-1:0] rand_text;
		seed = 32'he8b9;
		hc = '0;
		vc = '0;
		text = {"01AF", "F A1"};
		checks = 0;
		sq_errors = 0;
		ch_errors = 0;
		other_errors = 0;
		timeouts = 0;
		guard = 0;
		while (rst !== 1'b0 && guard < 20)	// wait for reset release
		begin
			@(posedge clk);
			guard++;
		end
		if (rst !== 1'b0)
		begin
			$display("timeout: reset was never released");
			timeouts++;
		end
		run_frame(0);
		text <= {"Z0 1", "AZF "};	// space and unsupported code
		run_frame(1);
		rand_text = '0;
		for (int i = 0; i < COLS * LINES; i++)
		begin
			pick = $unsigned($random(seed)) % 5;
			rand_text = {rand_text[8*COLS*LINES-9:0], charset[pick]};
		end
		text <= rand_text;
		run_frame(2);
		@(posedge clk);
		hc <= '0;	// park the beam, let the last pixel come out
		vc <= '0;
		@(posedge clk);
		$display("checks %0d, in_square errors %0d, in_character errors %0d, other %0d, timeouts %0d",
			checks, sq_errors, ch_errors, other_errors, timeouts);
		if (sq_errors + ch_errors + other_errors + timeouts == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end
endmodule
